//--- Makefile
TOP = storeBufferTb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- logic/busPkg.sv
`include "storeBuffer_defs.svh"

package busPkg;

    // Bus word address is the byte address without its lane bits.
    typedef logic [`SB_ADDR_WIDTH-3:0] wbAddress;

    typedef enum logic [1:0] {
        idle,   // Waiting for a buffered entry.
        write,  // Bus cycle open.
        retire  // Head entry is freed.
    } drainState;

endpackage

//--- logic/memTypesPkg.sv
`include "storeBuffer_defs.svh"

package memTypesPkg;

    // Data word as seen by the core and the bus.
    typedef logic [`SB_DATA_WIDTH-1:0] word;

    // Byte address from the core.
    typedef logic [`SB_ADDR_WIDTH-1:0] address;

    // One bit per byte lane for entry valid bytes and bus select.
    typedef logic [`SB_LANES-1:0] byteMask;

    typedef logic [$clog2(`SB_ENTRIES)-1:0] sbIndex; // Entry slot number.

endpackage

//--- logic/sbDrainIf.sv
`timescale 1ns/1ns

interface sbDrainIf;

    logic                 headValid;
    busPkg::wbAddress     headAddr;
    memTypesPkg::word     headData;
    memTypesPkg::byteMask headMask;
    logic                 retire; // One-cycle pulse that frees the head.

    modport buffer (
        output headValid, headAddr, headData, headMask,
        input  retire
    );

    modport master (
        input  headValid, headAddr, headData, headMask,
        output retire
    );

endinterface

//--- logic/sbSubsystem.sv
`timescale 1ns/1ns

module sbSubsystem (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 storeValid,
    input  logic                 loadValid,
    input  logic                 byteOp,
    input  memTypesPkg::address  addr,
    input  memTypesPkg::word     wdata,
    output memTypesPkg::word     rdata,
    output logic                 loadHit,
    output logic                 loadMiss,
    output logic                 stall,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output busPkg::wbAddress     wbAdr,
    output memTypesPkg::word     wbDatW,
    output memTypesPkg::byteMask wbSel,
    input  logic                 wbAck
);

    sbDrainIf i_sbDrainIf ();

    // Core side of the memory stage.
    storeBuffer i_storeBuffer (
        .clk        (clk),
        .rst        (rst),
        .storeValid (storeValid),
        .loadValid  (loadValid),
        .byteOp     (byteOp),
        .addr       (addr),
        .wdata      (wdata),
        .rdata      (rdata),
        .loadHit    (loadHit),
        .loadMiss   (loadMiss),
        .stall      (stall),
        .drain      (i_sbDrainIf.buffer)
    );

    // Memory side with one write in flight.
    wbDrainMaster i_wbDrainMaster (
        .clk    (clk),
        .rst    (rst),
        .drain  (i_sbDrainIf.master),
        .wbCyc  (wbCyc),
        .wbStb  (wbStb),
        .wbWe   (wbWe),
        .wbAdr  (wbAdr),
        .wbDatW (wbDatW),
        .wbSel  (wbSel),
        .wbAck  (wbAck)
    );

endmodule

//--- logic/storeBuffer.sv
`timescale 1ns/1ns
`include "storeBuffer_defs.svh"

module storeBuffer (
    input  logic                clk,
    input  logic                rst,
    input  logic                storeValid,
    input  logic                loadValid,
    input  logic                byteOp,
    input  memTypesPkg::address addr,
    input  memTypesPkg::word    wdata,
    output memTypesPkg::word    rdata,
    output logic                loadHit,
    output logic                loadMiss,
    output logic                stall,
    sbDrainIf.buffer            drain
);

    busPkg::wbAddress       entryAddr [`SB_ENTRIES];
    memTypesPkg::word       entryData [`SB_ENTRIES];
    memTypesPkg::byteMask   entryMask [`SB_ENTRIES];
    logic [`SB_ENTRIES-1:0] entryValid;

    memTypesPkg::sbIndex headPtr; // Oldest entry.
    memTypesPkg::sbIndex tailPtr; // Next free slot.

    busPkg::wbAddress     wordAddr;
    memTypesPkg::byteMask accessMask;
    memTypesPkg::word     accessBits;
    memTypesPkg::word     storeBits;

    logic                anyMatch;
    memTypesPkg::sbIndex youngIdx;
    logic                mergeMatch;
    memTypesPkg::sbIndex mergeIdx;
    logic                loadCovered;

    logic storeAccept;
    logic doMerge;
    logic doAlloc;

    // Spreads a lane mask over the bits of a word.
    function automatic memTypesPkg::word expandMask(input memTypesPkg::byteMask m);
        memTypesPkg::word bits;
        for (int b = 0; b < `SB_LANES; b++) begin
            bits[8*b +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    assign wordAddr   = addr[`SB_ADDR_WIDTH-1:2];
    assign accessMask = byteOp ? (memTypesPkg::byteMask'(1) << addr[1:0]) : '1;
    assign accessBits = expandMask(accessMask);
    assign storeBits  = wdata & accessBits; // Byte stores use their own lane.

    // Walk from oldest to youngest, so the last hit wins.
    always_comb begin
        memTypesPkg::sbIndex idx;
        anyMatch   = 1'b0;
        youngIdx   = headPtr;
        mergeMatch = 1'b0;
        mergeIdx   = headPtr;
        for (int k = 0; k < `SB_ENTRIES; k++) begin
            idx = headPtr + memTypesPkg::sbIndex'(k);
            if (entryValid[idx] && entryAddr[idx] == wordAddr) begin
                anyMatch = 1'b1;
                youngIdx = idx;
                // The master picks up a valid head on the next edge so it never takes a merge.
                if (k != 0) begin
                    mergeMatch = 1'b1;
                    mergeIdx   = idx;
                end
            end
        end
    end

    assign loadCovered = anyMatch && ((entryMask[youngIdx] & accessMask) == accessMask);

    assign stall       = &entryValid;
    assign storeAccept = storeValid && !stall;
    assign doMerge     = storeAccept && mergeMatch;
    assign doAlloc     = storeAccept && !mergeMatch;

    always_ff @(posedge clk) begin
        if (doAlloc) begin
            entryAddr[tailPtr] <= wordAddr;
            entryData[tailPtr] <= storeBits;
            entryMask[tailPtr] <= accessMask;
        end
        if (doMerge) begin
            entryData[mergeIdx] <= (entryData[mergeIdx] & ~accessBits) | storeBits;
            entryMask[mergeIdx] <= entryMask[mergeIdx] | accessMask;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
            headPtr    <= '0;
            tailPtr    <= '0;
        end else begin
            if (doAlloc) begin
                entryValid[tailPtr] <= 1'b1;
                tailPtr             <= tailPtr + memTypesPkg::sbIndex'(1);
            end
            if (drain.retire) begin
                entryValid[headPtr] <= 1'b0;
                headPtr             <= headPtr + memTypesPkg::sbIndex'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loadHit  <= 1'b0;
            loadMiss <= 1'b0;
        end else begin
            loadHit  <= loadValid && loadCovered;
            loadMiss <= loadValid && !loadCovered;
        end
    end

    always_ff @(posedge clk) begin
        if (loadValid) begin
            rdata <= loadCovered ? (entryData[youngIdx] & accessBits) : '0;
        end
    end

    assign drain.headValid = entryValid[headPtr];
    assign drain.headAddr  = entryAddr[headPtr];
    assign drain.headData  = entryData[headPtr];
    assign drain.headMask  = entryMask[headPtr];

    oneRequest: assert property (@(posedge clk) disable iff (rst)
        !(storeValid && loadValid))
        else $error("store and load requested in the same cycle");

    retireHasHead: assert property (@(posedge clk) disable iff (rst)
        drain.retire |-> drain.headValid)
        else $error("retire seen with no valid head entry");

    // The ring pointers and the valid bits must agree on a free tail.
    allocFree: assert property (@(posedge clk) disable iff (rst)
        doAlloc |-> !entryValid[tailPtr])
        else $error("store written into an occupied entry");

endmodule

//--- logic/storeBuffer_defs.svh
`ifndef STOREBUFFER_DEFS_SVH
`define STOREBUFFER_DEFS_SVH

// Buffer depth is a power of two so the ring pointers wrap on their own.
`define SB_ENTRIES 4

`define SB_ADDR_WIDTH 32 // Byte address.
`define SB_DATA_WIDTH 32

// Byte lanes per data word.
`define SB_LANES (`SB_DATA_WIDTH / 8)

`endif

//--- logic/wbDrainMaster.sv
`timescale 1ns/1ns

module wbDrainMaster (
    input  logic                 clk,
    input  logic                 rst,
    sbDrainIf.master             drain,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output busPkg::wbAddress     wbAdr,
    output memTypesPkg::word     wbDatW,
    output memTypesPkg::byteMask wbSel,
    input  logic                 wbAck
);

    busPkg::drainState state;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= busPkg::idle;
        end else begin
            unique case (state)
                busPkg::idle: begin
                    if (drain.headValid) begin
                        state <= busPkg::write;
                    end
                end
                busPkg::write: begin
                    if (wbAck) begin
                        state <= busPkg::retire; // Cycle ends on this edge.
                    end
                end
                busPkg::retire: begin
                    state <= busPkg::idle;
                end
                default: begin
                    state <= busPkg::idle;
                end
            endcase
        end
    end

    // Head fields are captured as the cycle opens.
    always_ff @(posedge clk) begin
        if (state == busPkg::idle && drain.headValid) begin
            wbAdr  <= drain.headAddr;
            wbDatW <= drain.headData;
            wbSel  <= drain.headMask;
        end
    end

    assign wbCyc = (state == busPkg::write);
    assign wbStb = wbCyc;
    assign wbWe  = wbCyc; // Write-only master.

    assign drain.retire = (state == busPkg::retire);

    // Every buffered entry holds at least one byte, so sel is never empty.
    selNotEmpty: assert property (@(posedge clk) disable iff (rst)
        wbStb |-> wbSel != '0)
        else $error("strobe with no byte selected");

    // The buffer keeps the head entry unchanged until retire.
    busHeld: assert property (@(posedge clk) disable iff (rst)
        wbStb |-> drain.headValid && wbAdr == drain.headAddr
            && wbDatW == drain.headData && wbSel == drain.headMask)
        else $error("head entry changed while its bus write was open");

endmodule

//--- sim.f
+incdir+logic
logic/memTypesPkg.sv
logic/busPkg.sv
logic/sbDrainIf.sv
logic/storeBuffer.sv
logic/wbDrainMaster.sv
logic/sbSubsystem.sv
test/storeBufferChecker.sv
test/storeBufferTb.sv

//--- test/storeBufferChecker.sv
`timescale 1ns/1ns
`include "storeBuffer_defs.svh"

module storeBufferChecker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 storeValid,
    input  logic                 loadValid,
    input  logic                 byteOp,
    input  memTypesPkg::address  addr,
    input  memTypesPkg::word     wdata,
    input  memTypesPkg::word     rdata,
    input  logic                 loadHit,
    input  logic                 loadMiss,
    input  logic                 stall,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  busPkg::wbAddress     wbAdr,
    input  memTypesPkg::word     wbDatW,
    input  memTypesPkg::byteMask wbSel,
    input  logic                 wbAck,
    input  logic                 expectHit,
    input  logic [159:0]         testName,
    input  logic                 endOfTest,
    output int                   valueErrors,
    output int                   protocolErrors
);

    // Shadow buffer with the oldest entry at index 0.
    busPkg::wbAddress     qAddr [$];
    memTypesPkg::word     qData [$];
    memTypesPkg::byteMask qMask [$];
    logic [159:0]         qName [$];

    memTypesPkg::word expMem [busPkg::wbAddress];
    memTypesPkg::word busMem [busPkg::wbAddress];

    logic             afterReset;
    logic             popNext; // Entry leaves one edge after its ack.
    logic             loadPending;
    logic             pendHit;
    memTypesPkg::word pendData;
    logic [159:0]     pendName;
    logic             finalDone;

    initial begin
        valueErrors    = 0;
        protocolErrors = 0;
    end

    function automatic memTypesPkg::byteMask laneMask(input logic isByte, input logic [1:0] lane);
        memTypesPkg::byteMask m;
        m = isByte ? (4'b0001 << lane) : 4'b1111;
        return m;
    endfunction

    function automatic memTypesPkg::word laneBits(input memTypesPkg::byteMask m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    function automatic memTypesPkg::word mergeBytes(input memTypesPkg::word old,
                                                    input memTypesPkg::word data,
                                                    input memTypesPkg::byteMask m);
        return (old & ~laneBits(m)) | (data & laneBits(m));
    endfunction

    task automatic valueFail(input logic [159:0] name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        valueErrors++;
        $display("[FAIL] %0s: %0s expected %h, actual %h", name, what, expected, actual);
    endtask

    task automatic protocolFail(input string msg);
        protocolErrors++;
        $display("Error at %0t ns: %0s", $time, msg);
    endtask

    always @(posedge clk) begin
        busPkg::wbAddress     wa;
        memTypesPkg::byteMask m;
        memTypesPkg::word     bits;
        int                   young;
        int                   mergeAt;
        logic                 doPop;
        if (rst) begin
            qAddr.delete();
            qData.delete();
            qMask.delete();
            qName.delete();
            afterReset  = 1'b1;
            popNext     = 1'b0;
            loadPending = 1'b0;
            finalDone   = 1'b0;
        end else begin
            doPop   = popNext;
            popNext = 1'b0;
            if (afterReset && (stall || wbCyc || wbStb || loadHit || loadMiss)) begin
                protocolFail("stall, bus or load outputs were not low right after reset");
            end
            afterReset = 1'b0;
            if (loadPending) begin
                if (loadHit !== pendHit || loadMiss !== !pendHit) begin
                    valueFail(pendName, "load hit", pendHit, loadHit);
                end else if (pendHit && rdata !== pendData) begin
                    valueFail(pendName, "load data", pendData, rdata);
                end
            end else if (loadHit || loadMiss) begin
                protocolFail("load response came without a load one cycle earlier");
            end
            if (stall !== (qAddr.size() == `SB_ENTRIES)) begin
                valueFail(testName, "stall", qAddr.size() == `SB_ENTRIES, stall);
            end
            if (wbCyc && wbStb && wbAck) begin
                if (qAddr.size() == 0) begin
                    protocolFail("bus write seen with no buffered store");
                end else begin
                    if (!wbWe) begin
                        protocolFail("bus cycle ran without write enable");
                    end
                    if (wbAdr !== qAddr[0]) valueFail(qName[0], "bus address", qAddr[0], wbAdr);
                    if (wbSel !== qMask[0]) valueFail(qName[0], "bus select", qMask[0], wbSel);
                    if (wbDatW !== qData[0]) valueFail(qName[0], "bus data", qData[0], wbDatW);
                    wa = qAddr[0];
                    expMem[wa] = mergeBytes(expMem.exists(wa) ? expMem[wa] : '0, qData[0], qMask[0]);
                    busMem[wbAdr] = mergeBytes(busMem.exists(wbAdr) ? busMem[wbAdr] : '0,
                                               wbDatW, wbSel);
                    popNext = 1'b1;
                end
            end
            loadPending = loadValid;
            if (loadValid) begin
                wa    = addr[31:2];
                m     = laneMask(byteOp, addr[1:0]);
                young = -1;
                foreach (qAddr[i]) begin
                    if (qAddr[i] == wa) young = i; // Youngest match wins.
                end
                pendHit  = expectHit;
                pendName = testName;
                pendData = (young >= 0) ? (qData[young] & laneBits(m)) : '0;
                if (((young >= 0) && ((qMask[young] & m) == m)) !== expectHit) begin
                    protocolFail("stimulus table and reference model disagree on a load");
                end
            end
            if (storeValid && qAddr.size() < `SB_ENTRIES) begin
                wa      = addr[31:2];
                m       = laneMask(byteOp, addr[1:0]);
                bits    = laneBits(m);
                mergeAt = 0;
                for (int i = 1; i < qAddr.size(); i++) begin
                    if (qAddr[i] == wa) mergeAt = i; // Head entry never takes a merge.
                end
                if (mergeAt > 0) begin
                    qData[mergeAt] = mergeBytes(qData[mergeAt], wdata, m);
                    qMask[mergeAt] = qMask[mergeAt] | m;
                end else begin
                    qAddr.push_back(wa);
                    qData.push_back(wdata & bits);
                    qMask.push_back(m);
                    qName.push_back(testName);
                end
            end
            if (doPop) begin
                void'(qAddr.pop_front());
                void'(qData.pop_front());
                void'(qMask.pop_front());
                void'(qName.pop_front());
            end
            if (endOfTest && !finalDone) begin
                finalDone = 1'b1;
                if (qAddr.size() != 0 || wbCyc) begin
                    protocolFail("stores were still buffered at the end of the test");
                end
                foreach (expMem[a]) begin
                    if (!busMem.exists(a) || busMem[a] !== expMem[a]) begin
                        valueFail("final memory", "memory word", expMem[a],
                                  busMem.exists(a) ? busMem[a] : '0);
                    end
                end
            end
        end
    end

endmodule

//--- test/storeBufferTb.sv
`timescale 1ns/1ns

module storeBufferTb;

    typedef enum logic [1:0] {opIdle, opStore, opLoad} opKind;

    typedef struct {
        opKind                kind;
        logic                 isByte;
        memTypesPkg::address  addr;
        memTypesPkg::word     wdata;
        logic                 expectHit;
        logic                 holdAck;
        int                   cycles;
        logic [159:0]         name;
    } tableRow;

    logic clk;
    logic rst;
    logic storeValid;
    logic loadValid;
    logic byteOp;
    memTypesPkg::address  addr;
    memTypesPkg::word     wdata;
    memTypesPkg::word     rdata;
    logic loadHit;
    logic loadMiss;
    logic stall;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    busPkg::wbAddress     wbAdr;
    memTypesPkg::word     wbDatW;
    memTypesPkg::byteMask wbSel;
    logic wbAck;

    logic         expectHit;
    logic         holdAck;   // Memory withholds ack while set.
    logic         endOfTest;
    logic [159:0] testName;
    int           valueErrors;
    int           protocolErrors;

    tableRow rows [$];
    integer  seed;
    int      waitLeft;
    int      cycleCount;
    int      cycleLimit;

    sbSubsystem i_sbSubsystem (
        .clk(clk), .rst(rst), .storeValid(storeValid), .loadValid(loadValid),
        .byteOp(byteOp), .addr(addr), .wdata(wdata), .rdata(rdata),
        .loadHit(loadHit), .loadMiss(loadMiss), .stall(stall),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbSel(wbSel), .wbAck(wbAck)
    );

    storeBufferChecker i_storeBufferChecker (
        .clk(clk), .rst(rst), .storeValid(storeValid), .loadValid(loadValid),
        .byteOp(byteOp), .addr(addr), .wdata(wdata), .rdata(rdata),
        .loadHit(loadHit), .loadMiss(loadMiss), .stall(stall),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatW(wbDatW), .wbSel(wbSel), .wbAck(wbAck),
        .expectHit(expectHit), .testName(testName), .endOfTest(endOfTest),
        .valueErrors(valueErrors), .protocolErrors(protocolErrors)
    );

    task automatic addRow(input opKind kind, input logic isByte, input memTypesPkg::address a,
                          input memTypesPkg::word d, input logic hit, input logic hold,
                          input int cycles, input logic [159:0] name);
        tableRow r;
        r.kind      = kind;
        r.isByte    = isByte;
        r.addr      = a;
        r.wdata     = d;
        r.expectHit = hit;
        r.holdAck   = hold;
        r.cycles    = cycles;
        r.name      = name;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        addRow(opStore, 1'b0, 32'h100, 32'h11112222, 1'b0, 1'b1, 1, "word stores");
        addRow(opLoad,  1'b0, 32'h100, 32'h0,        1'b1, 1'b1, 1, "word load hit");
        addRow(opStore, 1'b0, 32'h104, 32'h33334444, 1'b0, 1'b1, 1, "word stores");
        addRow(opStore, 1'b0, 32'h108, 32'h55556666, 1'b0, 1'b1, 1, "word stores");
        addRow(opLoad,  1'b1, 32'h10b, 32'h0,        1'b1, 1'b1, 1, "byte load hit");
        addRow(opLoad,  1'b0, 32'h200, 32'h0,        1'b0, 1'b1, 1, "absent load miss");
        addRow(opStore, 1'b0, 32'h104, 32'haaaabbbb, 1'b0, 1'b1, 1, "word merge");
        addRow(opLoad,  1'b0, 32'h104, 32'h0,        1'b1, 1'b1, 1, "youngest data");
        addRow(opStore, 1'b0, 32'h100, 32'h77778888, 1'b0, 1'b1, 1, "head store allocates");
        addRow(opLoad,  1'b0, 32'h100, 32'h0,        1'b1, 1'b1, 1, "youngest of two");
        addRow(opIdle,  1'b0, 32'h0,   32'h0,        1'b0, 1'b0, 30, "drain word stores");
        addRow(opStore, 1'b0, 32'h140, 32'hdeadbeef, 1'b0, 1'b1, 1, "byte merge");
        addRow(opStore, 1'b1, 32'h180, 32'h123456aa, 1'b0, 1'b1, 1, "byte merge");
        addRow(opStore, 1'b1, 32'h182, 32'hffccffff, 1'b0, 1'b1, 1, "byte merge");
        addRow(opLoad,  1'b0, 32'h180, 32'h0,        1'b0, 1'b1, 1, "partial load miss");
        addRow(opLoad,  1'b1, 32'h182, 32'h0,        1'b1, 1'b1, 1, "byte lane hit");
        addRow(opLoad,  1'b1, 32'h181, 32'h0,        1'b0, 1'b1, 1, "byte lane miss");
        addRow(opLoad,  1'b0, 32'h140, 32'h0,        1'b1, 1'b1, 1, "head load hit");
        addRow(opIdle,  1'b0, 32'h0,   32'h0,        1'b0, 1'b0, 30, "drain merged");
        addRow(opStore, 1'b0, 32'h400, 32'h40000001, 1'b0, 1'b1, 1, "fill buffer");
        addRow(opStore, 1'b0, 32'h404, 32'h40000002, 1'b0, 1'b1, 1, "fill buffer");
        addRow(opStore, 1'b0, 32'h408, 32'h40000003, 1'b0, 1'b1, 1, "fill buffer");
        addRow(opStore, 1'b0, 32'h40c, 32'h40000004, 1'b0, 1'b1, 1, "fill buffer");
        addRow(opLoad,  1'b0, 32'h408, 32'h0,        1'b1, 1'b1, 1, "load while full");
        addRow(opStore, 1'b0, 32'h410, 32'h40000005, 1'b0, 1'b0, 1, "store while full");
        addRow(opLoad,  1'b0, 32'h410, 32'h0,        1'b1, 1'b0, 1, "load after stall");
        addRow(opIdle,  1'b0, 32'h0,   32'h0,        1'b0, 1'b0, 40, "final drain");
    endtask

    // One row per accepted cycle; a stalled store stays on the inputs.
    task automatic applyRow(input tableRow row);
        int n;
        testName   = row.name;
        holdAck    = row.holdAck;
        expectHit  = row.expectHit;
        byteOp     = row.isByte;
        addr       = row.addr;
        wdata      = row.wdata;
        storeValid = (row.kind == opStore);
        loadValid  = (row.kind == opLoad);
        n          = row.cycles;
        while (n > 0) begin
            if (!(storeValid && stall)) begin
                n--;
            end
            @(posedge clk);
            #5;
        end
        storeValid = 1'b0;
        loadValid  = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Wishbone slave with 0 to 3 wait states per cycle.
    initial begin
        seed     = 32'hff5c8ee6;
        wbAck    = 1'b0;
        waitLeft = 0;
        forever begin
            @(posedge clk);
            #2;
            if (wbAck || !wbCyc) begin
                wbAck    = 1'b0;
                waitLeft = $unsigned($random(seed)) % 4;
            end else if (!holdAck) begin
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: test did not finish within %0d cycles.", cycleLimit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        rst        = 1'b1;
        storeValid = 1'b0;
        loadValid  = 1'b0;
        byteOp     = 1'b0;
        addr       = '0;
        wdata      = '0;
        expectHit  = 1'b0;
        holdAck    = 1'b0;
        endOfTest  = 1'b0;
        testName   = "reset";
        cycleCount = 0;
        buildTable();
        cycleLimit = rows.size() * 8 + 100;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
        foreach (rows[i]) begin
            applyRow(rows[i]);
        end
        endOfTest = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        $display("Errors: %0d value, %0d protocol.", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
